// ==== src/bpi_pkg.sv ====
package bpi_pkg;

  //////////////////////////////////////////////////////////////////////
  // Word and field types
  //////////////////////////////////////////////////////////////////////
  typedef logic [15:0] word_t;       // Command, data or status word
  typedef logic [22:0] addr_t;       // PROM word address
  typedef logic [4:0]  cmd_code_t;   // Header bits 4:0
  typedef logic [1:0]  bus_op_t;
  typedef logic [1:0]  read_mode_t;

  // Host command codes
  localparam cmd_code_t NoOp            = 5'h00;
  localparam cmd_code_t Read_1          = 5'h02;
  localparam cmd_code_t Read_n          = 5'h04;
  localparam cmd_code_t Read_Array      = 5'h05;
  localparam cmd_code_t Read_Status_Reg = 5'h06;
  localparam cmd_code_t Clr_Status_Reg  = 5'h09;
  localparam cmd_code_t Block_Erase     = 5'h0A;
  localparam cmd_code_t Load_Address    = 5'h17;   // Local, takes an offset word
  localparam cmd_code_t Clr_BPI_Status  = 5'h1C;   // Local

  localparam bus_op_t BUS_OP_WRITE = 2'd1;
  localparam bus_op_t BUS_OP_READ  = 2'd2;

  // PROM read modes
  localparam read_mode_t RD_ARRAY = 2'd0;
  localparam read_mode_t RD_SR    = 2'd1;
  localparam read_mode_t RD_ESIG  = 2'd2;
  localparam read_mode_t RD_CFIQ  = 2'd3;

  //////////////////////////////////////////////////////////////////////
  // PROM opcodes and address masks
  //////////////////////////////////////////////////////////////////////
  localparam word_t OPC_READ_ARRAY  = 16'h00FF;
  localparam word_t OPC_READ_SR     = 16'h0070;
  localparam word_t OPC_CLR_SR      = 16'h0050;
  localparam word_t OPC_ERASE_SETUP = 16'h0020;
  localparam word_t OPC_CONFIRM     = 16'h00D0;

  localparam addr_t BANK_MASK         = 23'h780000;
  localparam addr_t PARAM_BLOCK_LIMIT = 23'h7EFFFF;   // 16 KWord blocks above this
  localparam addr_t PARAM_BLOCK_MASK  = 23'h7FC000;
  localparam addr_t MAIN_BLOCK_MASK   = 23'h7F0000;   // 64 KWord blocks

  localparam int         SR_READY_BIT      = 7;
  localparam logic [7:0] SR_ERASE_ERR_MASK = 8'h2A;

  localparam int CMD_FIFO_DEPTH = 64;
  localparam int RBK_FIFO_DEPTH = 64;
  localparam int COUNT_W        = 11;   // Header bits 15:5

endpackage

// ==== src/bpi_word_fifo.sv ====
`timescale 1ns/100ps

module bpi_word_fifo
  import bpi_pkg::*;
#(
  parameter int DEPTH = CMD_FIFO_DEPTH
)
(
  input  logic               CLK,
  input  logic               local_rst,
  input  logic               wr_en,
  input  word_t              wr_data,
  input  logic               rd_en,
  output word_t              rd_data,
  output logic               empty,
  output logic               full,
  output logic [COUNT_W-1:0] count,
  output logic               wr_overflow
);

  localparam int PTR_W = $clog2(DEPTH);

  word_t            mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic             do_wr;
  logic             do_rd;

  assign do_wr       = wr_en && !full;
  assign do_rd       = rd_en && !empty;
  assign wr_overflow = wr_en && full;             // Word is dropped
  assign empty       = (count == '0);
  assign full        = (count == COUNT_W'(DEPTH));
  assign rd_data     = mem[rd_ptr];               // Head word, show-ahead

  always_ff @(posedge CLK)
  begin
    if (do_wr)
      mem[wr_ptr] <= wr_data;
  end

  always_ff @(posedge CLK or posedge local_rst)
  begin
    if (local_rst)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (do_wr)
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (do_rd)
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;                  // Idle or both at once
      endcase
    end
  end

  // Readers look at empty before popping
  a_no_pop_empty: assert property (@(posedge CLK) disable iff (local_rst)
    rd_en |-> !empty);

endmodule

// ==== src/bpi_cmd_parser.sv ====
`timescale 1ns/100ps

module bpi_cmd_parser
  import bpi_pkg::*;
(
  input  logic               CLK,
  input  logic               local_rst,
  input  logic               enable_set,
  input  logic               enable_clr,
  input  word_t              fifo_word,
  input  logic               fifo_empty,
  output logic               fifo_pop,
  output logic               op_start,
  output cmd_code_t          op_code,
  output logic [COUNT_W-1:0] op_count,
  output logic               addr_load,
  output addr_t              addr_value,
  input  logic               seq_idle,
  output logic               clr_status
);

  typedef enum logic [2:0] {
    P_IDLE,
    P_HEADER,
    P_EXTRA,
    P_ISSUE,
    P_WAIT
  } parse_state_t;

  parse_state_t       state;
  parse_state_t       next_state;
  logic               enabled;
  cmd_code_t          hdr_code;
  logic [COUNT_W-1:0] hdr_arg;
  logic [COUNT_W-1:0] arg_reg;
  logic               prom_cmd;

  assign hdr_code = fifo_word[4:0];
  assign hdr_arg  = fifo_word[15:5];

  // Codes handed to the sequencer
  always_comb
  begin
    case (hdr_code)
      Read_1, Read_n, Read_Array, Read_Status_Reg, Clr_Status_Reg, Block_Erase:
        prom_cmd = 1'b1;
      default:
        prom_cmd = 1'b0;
    endcase
  end

  always_comb
  begin
    next_state = state;
    case (state)
      P_IDLE:
        if (enabled && !fifo_empty)
          next_state = P_HEADER;
      P_HEADER:
        if (hdr_code == Load_Address)
          next_state = P_EXTRA;
        else if (prom_cmd)
          next_state = P_ISSUE;
        else
          next_state = P_IDLE;                    // Local or unknown code ends here
      P_EXTRA:
        if (addr_load)
          next_state = P_IDLE;
      P_ISSUE:
        if (seq_idle)
          next_state = P_WAIT;
      P_WAIT:
        if (seq_idle)
          next_state = P_IDLE;
      default:
        next_state = P_IDLE;
    endcase
  end

  assign addr_load  = (state == P_EXTRA) && !fifo_empty && seq_idle;
  assign fifo_pop   = (state == P_HEADER) || addr_load;
  assign addr_value = {arg_reg[6:0], fifo_word};  // Base and offset
  assign op_start   = (state == P_ISSUE) && seq_idle;
  assign op_count   = (op_code == Read_n) ? arg_reg : '0;
  assign clr_status = (state == P_HEADER) && (hdr_code == Clr_BPI_Status);

  always_ff @(posedge CLK or posedge local_rst)
  begin
    if (local_rst)
    begin
      state   <= P_IDLE;
      enabled <= 1'b0;
      op_code <= NoOp;
    end
    else
    begin
      state <= next_state;
      if (enable_set)
        enabled <= 1'b1;
      else if (enable_clr)
        enabled <= 1'b0;
      if ((state == P_HEADER) && prom_cmd)
        op_code <= hdr_code;
    end
  end

  always_ff @(posedge CLK)
  begin
    if (state == P_HEADER)
      arg_reg <= hdr_arg;                         // n-1 or base address
  end

  // Sequencer leaves idle right after a start
  a_start_idle: assert property (@(posedge CLK) disable iff (local_rst)
    op_start |=> !seq_idle);

endmodule

// ==== src/bpi_bus_sequencer.sv ====
`timescale 1ns/100ps

module bpi_bus_sequencer
  import bpi_pkg::*;
(
  input  logic               CLK,
  input  logic               local_rst,
  input  logic               op_start,
  input  cmd_code_t          op_code,
  input  logic [COUNT_W-1:0] op_count,
  input  logic               addr_load,
  input  addr_t              addr_value,
  output logic               seq_idle,
  input  logic               rbk_full,
  input  logic               sr_ready,
  input  logic               bus_busy,
  input  logic               bus_load_data,
  output logic               bus_execute,
  output bus_op_t            bus_op,
  output addr_t              bus_addr,
  output word_t              bus_data_to,
  output logic               rbk_push,
  output cmd_code_t          mode_cmd
);

  typedef enum logic [3:0] {
    S_IDLE,
    S_CMD,
    S_CMD_WAIT,
    S_CONF,
    S_CONF_WAIT,
    S_POLL,
    S_POLL_WAIT,
    S_READ,
    S_READ_WAIT
  } seq_state_t;

  seq_state_t         state;
  cmd_code_t          cur_op;
  logic [COUNT_W-1:0] reads_left;
  addr_t              ptr;          // Base in 22:16 and offset in 15:0
  addr_t              bank_addr;
  addr_t              block_addr;
  logic               issue;

  assign seq_idle   = (state == S_IDLE);
  assign bank_addr  = ptr & BANK_MASK;
  assign block_addr = (ptr > PARAM_BLOCK_LIMIT) ? (ptr & PARAM_BLOCK_MASK)
                                                : (ptr & MAIN_BLOCK_MASK);

  //////////////////////////////////////////////////////////////////////
  // Bus cycle outputs
  //////////////////////////////////////////////////////////////////////
  assign issue = (state == S_CMD) || (state == S_CONF) || (state == S_POLL) ||
                 ((state == S_READ) && !rbk_full);     // Hold reads on full FIFO
  assign bus_execute = issue && !bus_busy;
  assign bus_op = ((state == S_POLL) || (state == S_POLL_WAIT) || (state == S_READ) ||
                   (state == S_READ_WAIT)) ? BUS_OP_READ : BUS_OP_WRITE;
  assign rbk_push = bus_load_data && (state == S_READ_WAIT);
  assign mode_cmd = (seq_idle && op_start) ? op_code : NoOp;

  always_comb
  begin
    case (cur_op)
      Block_Erase:    bus_addr = block_addr;
      Read_1, Read_n: bus_addr = ptr;
      default:        bus_addr = bank_addr;
    endcase
  end

  always_comb
  begin
    if (state == S_CONF)
      bus_data_to = OPC_CONFIRM;
    else
      case (cur_op)
        Read_Array:      bus_data_to = OPC_READ_ARRAY;
        Read_Status_Reg: bus_data_to = OPC_READ_SR;
        Clr_Status_Reg:  bus_data_to = OPC_CLR_SR;
        Block_Erase:     bus_data_to = OPC_ERASE_SETUP;
        default:         bus_data_to = '0;           // Reads
      endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Sequence FSM and address pointer
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge CLK or posedge local_rst)
  begin
    if (local_rst)
    begin
      state      <= S_IDLE;
      cur_op     <= NoOp;
      reads_left <= '0;
      ptr        <= '0;
    end
    else
    begin
      case (state)
        S_IDLE:
        begin
          if (addr_load)
            ptr <= addr_value;
          if (op_start)
          begin
            cur_op     <= op_code;
            reads_left <= op_count;
            case (op_code)
              Read_1, Read_n:
                state <= S_READ;
              Read_Array, Read_Status_Reg, Clr_Status_Reg, Block_Erase:
                state <= S_CMD;
              default:
                state <= S_IDLE;
            endcase
          end
        end
        S_CMD:
          if (bus_execute)
            state <= S_CMD_WAIT;
        S_CMD_WAIT:
          if (!bus_busy)
            state <= (cur_op == Block_Erase) ? S_CONF : S_IDLE;
        S_CONF:
          if (bus_execute)
            state <= S_CONF_WAIT;
        S_CONF_WAIT:
          if (!bus_busy)
            state <= S_POLL;
        S_POLL:
          if (bus_execute)
            state <= S_POLL_WAIT;
        S_POLL_WAIT:
          if (!bus_busy)
            state <= sr_ready ? S_IDLE : S_POLL;  // Poll until erase done
        S_READ:
          if (bus_execute)
            state <= S_READ_WAIT;
        S_READ_WAIT:
          if (!bus_busy)
          begin
            ptr[15:0] <= ptr[15:0] + 1'b1;
            if (reads_left == '0)
              state <= S_IDLE;
            else
            begin
              reads_left <= reads_left - 1'b1;
              state      <= S_READ;
            end
          end
        default:
          state <= S_IDLE;
      endcase
    end
  end

  // Flash answers every execute with busy
  a_exec_busy: assert property (@(posedge CLK) disable iff (local_rst)
    bus_execute |=> bus_busy);

  a_push_room: assert property (@(posedge CLK) disable iff (local_rst)
    rbk_push |-> !rbk_full);

endmodule

// ==== src/bpi_status_capture.sv ====
`timescale 1ns/100ps

module bpi_status_capture
  import bpi_pkg::*;
(
  input  logic      CLK,
  input  logic      local_rst,
  input  cmd_code_t mode_cmd,
  input  logic      bus_load_data,
  input  word_t     bus_data_from,
  input  logic      clr_status,
  input  logic      cmd_empty,
  input  logic      cmd_full,
  input  logic      cmd_overflow,
  input  logic      rbk_empty,
  input  logic      rbk_full,
  input  logic      rbk_overflow,
  output logic      sr_ready,
  output word_t     bpi_status
);

  read_mode_t read_mode;
  logic       capture_sr;
  logic [7:0] sr_reg;
  logic       cmd_ovf_sticky;
  logic       rbk_ovf_sticky;

  assign sr_ready   = sr_reg[SR_READY_BIT];
  assign bpi_status = {rbk_empty, rbk_full, 1'b0, rbk_ovf_sticky,
                       cmd_empty, cmd_full, 1'b0, cmd_ovf_sticky, sr_reg};

  always_comb
  begin
    case (read_mode)
      RD_SR:                      capture_sr = 1'b1;
      RD_ARRAY, RD_ESIG, RD_CFIQ: capture_sr = 1'b0;  // Data only to readback
    endcase
  end

  always_ff @(posedge CLK or posedge local_rst)
  begin
    if (local_rst)
    begin
      read_mode      <= RD_ARRAY;
      sr_reg         <= '0;
      cmd_ovf_sticky <= 1'b0;
      rbk_ovf_sticky <= 1'b0;
    end
    else
    begin
      case (mode_cmd)
        Read_Array:                   read_mode <= RD_ARRAY;
        Read_Status_Reg, Block_Erase: read_mode <= RD_SR;
        default:                      read_mode <= read_mode;
      endcase
      if (bus_load_data && capture_sr)
        sr_reg <= bus_data_from[7:0];
      else if (clr_status)
        sr_reg <= sr_reg & ~(SR_ERASE_ERR_MASK | 8'h10);  // Erase and program errors
      cmd_ovf_sticky <= !clr_status && (cmd_ovf_sticky || cmd_overflow);
      rbk_ovf_sticky <= !clr_status && (rbk_ovf_sticky || rbk_overflow);
    end
  end

endmodule

// ==== src/bpi_ctrl.sv ====
`timescale 1ns/100ps

module bpi_ctrl
  import bpi_pkg::*;
(
  input  logic               CLK,
  input  logic               local_rst,
  // Host side
  input  word_t              cmd_data,
  input  logic               cmd_we,
  input  logic               rbk_re,
  input  logic               parse_enable,
  input  logic               parse_disable,
  output word_t              rbk_data,
  output logic [COUNT_W-1:0] rbk_word_count,
  output word_t              bpi_status,
  // Flash bus
  input  logic               bus_busy,
  input  word_t              bus_data_from,
  input  logic               bus_load_data,
  output bus_op_t            bus_op,
  output addr_t              bus_addr,
  output word_t              bus_data_to,
  output logic               bus_execute
);

  word_t              cmd_word;
  logic               cmd_pop;
  logic               cmd_empty;
  logic               cmd_full;
  logic               cmd_overflow;
  logic               rbk_push;
  logic               rbk_empty;
  logic               rbk_full;
  logic               rbk_overflow;
  logic               op_start;
  cmd_code_t          op_code;
  logic [COUNT_W-1:0] op_count;
  logic               addr_load;
  addr_t              addr_value;
  logic               seq_idle;
  logic               clr_status;
  cmd_code_t          mode_cmd;
  logic               sr_ready;

  bpi_word_fifo #(.DEPTH(CMD_FIFO_DEPTH)) cmd_fifo (
    .CLK(CLK), .local_rst(local_rst), .wr_en(cmd_we), .wr_data(cmd_data),
    .rd_en(cmd_pop), .rd_data(cmd_word), .empty(cmd_empty), .full(cmd_full),
    .count(), .wr_overflow(cmd_overflow)
  );

  bpi_word_fifo #(.DEPTH(RBK_FIFO_DEPTH)) rbk_fifo (
    .CLK(CLK), .local_rst(local_rst), .wr_en(rbk_push), .wr_data(bus_data_from),
    .rd_en(rbk_re), .rd_data(rbk_data), .empty(rbk_empty), .full(rbk_full),
    .count(rbk_word_count), .wr_overflow(rbk_overflow)
  );

  bpi_cmd_parser parser (
    .CLK(CLK), .local_rst(local_rst), .enable_set(parse_enable),
    .enable_clr(parse_disable), .fifo_word(cmd_word), .fifo_empty(cmd_empty),
    .fifo_pop(cmd_pop), .op_start(op_start), .op_code(op_code), .op_count(op_count),
    .addr_load(addr_load), .addr_value(addr_value), .seq_idle(seq_idle),
    .clr_status(clr_status)
  );

  bpi_bus_sequencer sequencer (
    .CLK(CLK), .local_rst(local_rst), .op_start(op_start), .op_code(op_code),
    .op_count(op_count), .addr_load(addr_load), .addr_value(addr_value),
    .seq_idle(seq_idle), .rbk_full(rbk_full), .sr_ready(sr_ready),
    .bus_busy(bus_busy), .bus_load_data(bus_load_data), .bus_execute(bus_execute),
    .bus_op(bus_op), .bus_addr(bus_addr), .bus_data_to(bus_data_to),
    .rbk_push(rbk_push), .mode_cmd(mode_cmd)
  );

  bpi_status_capture status (
    .CLK(CLK), .local_rst(local_rst), .mode_cmd(mode_cmd),
    .bus_load_data(bus_load_data), .bus_data_from(bus_data_from),
    .clr_status(clr_status), .cmd_empty(cmd_empty), .cmd_full(cmd_full),
    .cmd_overflow(cmd_overflow), .rbk_empty(rbk_empty), .rbk_full(rbk_full),
    .rbk_overflow(rbk_overflow), .sr_ready(sr_ready), .bpi_status(bpi_status)
  );

endmodule

// ==== testbench/bpi_flash_model.sv ====
`timescale 1ns/100ps

module bpi_flash_model
  import bpi_pkg::*;
(
  input  logic       CLK,
  input  logic       local_rst,
  input  logic       bus_execute,
  input  bus_op_t    bus_op,
  input  addr_t      bus_addr,
  input  word_t      bus_data_to,
  input  logic [2:0] busy_len,      // Drawn by the testbench, 1 to 4
  input  logic [7:0] err_byte,      // Error bits reported by the next erase
  output logic       bus_busy,
  output logic       bus_load_data,
  output word_t      bus_data_from,
  output addr_t      last_wr_addr,
  output word_t      last_wr_data,
  output addr_t      prev_wr_addr,
  output word_t      prev_wr_data
);

  logic [2:0] busy_cnt;
  logic       is_read;
  word_t      rd_word;
  logic       sr_mode;
  logic       setup_seen;
  logic [1:0] poll_left;   // Status reads still answered as busy
  logic [7:0] sr;

  always_ff @(posedge CLK or posedge local_rst)
  begin
    if (local_rst)
    begin
      bus_busy      <= 1'b0;
      bus_load_data <= 1'b0;
      bus_data_from <= '0;
      busy_cnt      <= '0;
      is_read       <= 1'b0;
      rd_word       <= '0;
      sr_mode       <= 1'b0;
      setup_seen    <= 1'b0;
      poll_left     <= '0;
      sr            <= '0;
      last_wr_addr  <= '0;
      last_wr_data  <= '0;
      prev_wr_addr  <= '0;
      prev_wr_data  <= '0;
    end
    else
    begin
      bus_load_data <= 1'b0;
      if (bus_execute)
      begin
        bus_busy <= 1'b1;
        busy_cnt <= busy_len;
        is_read  <= (bus_op == BUS_OP_READ);
        if (bus_op == BUS_OP_READ)
        begin
          if (!sr_mode)
            rd_word <= bus_addr[15:0] ^ 16'hA5A5;   // Array data pattern
          else if (poll_left != '0)
          begin
            rd_word   <= 16'h0000;
            poll_left <= poll_left - 1'b1;
          end
          else
            rd_word <= {8'h00, sr};
        end
        else
        begin
          prev_wr_addr <= last_wr_addr;
          prev_wr_data <= last_wr_data;
          last_wr_addr <= bus_addr;
          last_wr_data <= bus_data_to;
          case (bus_data_to)
            16'h00FF: sr_mode <= 1'b0;
            16'h0070: sr_mode <= 1'b1;
            16'h0050: sr <= sr & ~8'h3A;
            16'h0020: setup_seen <= 1'b1;
            16'h00D0:
              if (setup_seen)
              begin
                sr_mode    <= 1'b1;
                poll_left  <= 2'd2;
                sr         <= 8'h80 | err_byte;
                setup_seen <= 1'b0;
              end
            default: setup_seen <= 1'b0;
          endcase
        end
      end
      else if (bus_busy)
      begin
        if (busy_cnt == 3'd1)
        begin
          bus_load_data <= is_read;              // One pulse before busy drops
          bus_data_from <= rd_word;
          busy_cnt      <= '0;
        end
        else if (busy_cnt == 3'd0)
          bus_busy <= 1'b0;
        else
          busy_cnt <= busy_cnt - 1'b1;
      end
    end
  end

endmodule

// ==== testbench/tb_bpi_ctrl.sv ====
`timescale 1ns/100ps

module tb_bpi_ctrl
  import bpi_pkg::*;
();

  localparam int MAX_BUSY     = 4;
  localparam int QUIET_CYCLES = 8;
  localparam int STEP_LIMIT   = 4000;

  typedef struct packed {
    word_t      hdr;
    word_t      ext;
    logic [7:0] err;
    addr_t      wr_addr;   // Expected address of the last bus write
  } entry_t;

  logic               CLK = 1'b0;
  logic               local_rst;
  word_t              cmd_data;
  logic               cmd_we;
  logic               rbk_re;
  logic               parse_enable;
  logic               parse_disable;
  word_t              rbk_data;
  logic [COUNT_W-1:0] rbk_word_count;
  word_t              bpi_status;
  logic               bus_busy;
  word_t              bus_data_from;
  logic               bus_load_data;
  bus_op_t            bus_op;
  addr_t              bus_addr;
  word_t              bus_data_to;
  logic               bus_execute;
  logic [2:0]         busy_len = 3'd1;
  logic [7:0]         err_byte;
  addr_t              last_wr_addr;
  word_t              last_wr_data;
  addr_t              prev_wr_addr;
  word_t              prev_wr_data;

  entry_t      stim_q[$];
  logic [31:0] lfsr = 32'h43df7699;
  addr_t       exp_ptr;
  logic [7:0]  exp_sr;
  logic        exp_sr_mode;   // Model answers reads with its status byte

  bpi_ctrl dut (
    .CLK(CLK), .local_rst(local_rst), .cmd_data(cmd_data), .cmd_we(cmd_we),
    .rbk_re(rbk_re), .parse_enable(parse_enable), .parse_disable(parse_disable),
    .rbk_data(rbk_data), .rbk_word_count(rbk_word_count), .bpi_status(bpi_status),
    .bus_busy(bus_busy), .bus_data_from(bus_data_from), .bus_load_data(bus_load_data),
    .bus_op(bus_op), .bus_addr(bus_addr), .bus_data_to(bus_data_to),
    .bus_execute(bus_execute)
  );

  bpi_flash_model flash (
    .CLK(CLK), .local_rst(local_rst), .bus_execute(bus_execute), .bus_op(bus_op),
    .bus_addr(bus_addr), .bus_data_to(bus_data_to), .busy_len(busy_len),
    .err_byte(err_byte), .bus_busy(bus_busy), .bus_load_data(bus_load_data),
    .bus_data_from(bus_data_from), .last_wr_addr(last_wr_addr),
    .last_wr_data(last_wr_data), .prev_wr_addr(prev_wr_addr),
    .prev_wr_data(prev_wr_data)
  );

  initial
  begin
    forever #4 CLK = ~CLK;
  end

  // Galois LFSR stepped once per bit taken
  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      v    = {v[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
    end
    return v;
  endfunction

  always @(negedge CLK)
    busy_len <= 3'(rand_bits(2)) + 3'd1;

  function automatic word_t make_hdr(cmd_code_t code, int arg);
    return {arg[10:0], code};
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////////////////////////
  task automatic check_word(string name, word_t got, word_t exp);
    if (got !== exp)
    begin
      $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
      $display("tests failed");
      $fatal(1);
    end
  endtask

  task automatic check_addr(string name, addr_t got, addr_t exp);
    if (got !== exp)
    begin
      $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
      $display("tests failed");
      $fatal(1);
    end
  endtask

  task automatic check_count(string name, logic [COUNT_W-1:0] got, int exp);
    if (got !== COUNT_W'(exp))
    begin
      $display("[ERROR] %0t %s got %0d expected %0d", $time, name, got, exp);
      $display("tests failed");
      $fatal(1);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Host side helpers driven on falling edges
  //////////////////////////////////////////////////////////////////////
  task automatic send_word(word_t w);
    cmd_data = w;
    cmd_we   = 1'b1;
    @(negedge CLK);
    cmd_we   = 1'b0;
  endtask

  task automatic pulse(ref logic sig);
    sig = 1'b1;
    @(negedge CLK);
    sig = 1'b0;
  endtask

  // Waits for an empty command FIFO, the readback count and a quiet bus
  task automatic wait_done(int exp_count);
    int quiet;
    int cycles;
    quiet  = 0;
    cycles = 0;
    while (quiet < QUIET_CYCLES)
    begin
      @(negedge CLK);
      cycles++;
      if (bpi_status[11] && (rbk_word_count == COUNT_W'(exp_count)) &&
          !bus_busy && !bus_execute)
        quiet++;
      else
        quiet = 0;
      if (cycles > STEP_LIMIT)
      begin
        $display("Command did not complete within %0d cycles", STEP_LIMIT);
        $display("tests failed");
        $fatal(1);
      end
    end
  endtask

  task automatic pop_and_check(int n);
    word_t exp;
    for (int i = 0; i < n; i++)
    begin
      exp = exp_sr_mode ? {8'h00, exp_sr} : (exp_ptr[15:0] ^ 16'hA5A5);
      check_word("rbk_data", rbk_data, exp);
      exp_ptr[15:0] = exp_ptr[15:0] + 16'd1;      // Offset wraps in 16 bits
      pulse(rbk_re);
    end
    check_count("rbk_word_count", rbk_word_count, 0);
  endtask

  task automatic apply_entry(entry_t e);
    cmd_code_t code;
    int        reads;
    code     = e.hdr[4:0];
    reads    = 0;
    err_byte = e.err;
    send_word(e.hdr);
    if (code == Load_Address)
      send_word(e.ext);
    case (code)
      Load_Address:    exp_ptr = {e.hdr[11:5], e.ext};
      Read_1:          reads = 1;
      Read_n:          reads = int'(e.hdr[15:5]) + 1;
      Read_Array:      exp_sr_mode = 1'b0;
      Read_Status_Reg: exp_sr_mode = 1'b1;
      Block_Erase:
      begin
        exp_sr_mode = 1'b1;
        exp_sr      = 8'h80 | e.err;
      end
      default:         reads = 0;
    endcase
    wait_done(reads);
    pop_and_check(reads);
    check_word("bpi_status[7:0]", {8'h00, bpi_status[7:0]}, {8'h00, exp_sr});
    if (code == Block_Erase)
    begin
      check_addr("setup bus_addr", prev_wr_addr, e.wr_addr);
      check_word("setup bus_data_to", prev_wr_data, 16'h0020);
      check_addr("confirm bus_addr", last_wr_addr, e.wr_addr);
      check_word("confirm bus_data_to", last_wr_data, 16'h00D0);
    end
    else if ((code == Read_Array) || (code == Read_Status_Reg))
    begin
      check_addr("mode bus_addr", last_wr_addr, e.wr_addr);
      check_word("mode bus_data_to", last_wr_data,
                 (code == Read_Array) ? 16'h00FF : 16'h0070);
    end
  endtask

  task automatic add_entry(word_t hdr, word_t ext, logic [7:0] err, addr_t wr_addr);
    entry_t e;
    e.hdr     = hdr;
    e.ext     = ext;
    e.err     = err;
    e.wr_addr = wr_addr;
    stim_q.push_back(e);
  endtask

  // Words queue up while parsing is off and run once it is on
  task automatic queued_commands_test();
    pulse(parse_disable);
    send_word(make_hdr(Load_Address, 7'h05));
    send_word(16'h1234);
    send_word(make_hdr(Read_n, 2));
    for (int i = 0; i < 60; i++)
      send_word(make_hdr(NoOp, 0));
    send_word(make_hdr(Clr_BPI_Status, 0));
    check_word("cmd flags full", bpi_status & 16'h0D00, 16'h0400);
    send_word(make_hdr(NoOp, 0));                 // 65th word is dropped
    check_word("cmd flags overflow", bpi_status & 16'h0D00, 16'h0500);
    exp_ptr = {7'h05, 16'h1234};
    pulse(parse_enable);
    wait_done(3);
    check_word("cmd flags cleared", bpi_status & 16'h0D00, 16'h0800);
    exp_sr = exp_sr & ~8'h3A;
    check_word("bpi_status[7:0]", {8'h00, bpi_status[7:0]}, {8'h00, exp_sr});
    pop_and_check(3);
  endtask

  initial
  begin
    int n;
    local_rst     = 1'b1;
    cmd_data      = '0;
    cmd_we        = 1'b0;
    rbk_re        = 1'b0;
    parse_enable  = 1'b0;
    parse_disable = 1'b0;
    err_byte      = '0;
    exp_ptr       = '0;
    exp_sr        = '0;
    exp_sr_mode   = 1'b0;

    add_entry(make_hdr(Load_Address, 7'h12), 16'h3456, 8'h00, '0);
    add_entry(make_hdr(Read_1, 0), 16'h0000, 8'h00, '0);
    n = int'(rand_bits(6) % 40) + 1;
    add_entry(make_hdr(Read_n, n - 1), 16'h0000, 8'h00, '0);
    add_entry(make_hdr(Load_Address, 7'h7F), 16'h5678, 8'h00, '0);   // Parameter block
    add_entry(make_hdr(Block_Erase, 0), 16'h0000, 8'h20, 23'h7F4000);
    add_entry(make_hdr(Read_Status_Reg, 0), 16'h0000, 8'h00, 23'h780000);
    add_entry(make_hdr(Read_1, 0), 16'h0000, 8'h00, '0);
    add_entry(make_hdr(Load_Address, 7'h2B), 16'hC001, 8'h00, '0);   // Main block
    add_entry(make_hdr(Block_Erase, 0), 16'h0000, 8'h0A, 23'h2B0000);
    add_entry(make_hdr(Read_Array, 0), 16'h0000, 8'h00, 23'h280000);
    n = int'(rand_bits(6) % 40) + 1;
    add_entry(make_hdr(Read_n, n - 1), 16'h0000, 8'h00, '0);

    repeat (16) @(posedge CLK);
    @(negedge CLK);
    local_rst = 1'b0;
    @(negedge CLK);
    check_word("bpi_status", bpi_status, 16'h8800);
    pulse(parse_enable);

    foreach (stim_q[i])
      apply_entry(stim_q[i]);
    queued_commands_test();

    $display("all tests passed");
    $finish;
  end

  // Watchdog sized from the table and the longest busy time
  initial
  begin
    int limit;
    #1;
    limit = (stim_q.size() + 2) * 48 * (MAX_BUSY + 4) + 3000;
    repeat (limit) @(posedge CLK);
    $display("Watchdog expired after %0d cycles", limit);
    $display("tests failed");
    $fatal(1);
  end

endmodule

// ==== bpi_ctrl.f ====
src/bpi_pkg.sv
src/bpi_word_fifo.sv
src/bpi_cmd_parser.sv
src/bpi_bus_sequencer.sv
src/bpi_status_capture.sv
src/bpi_ctrl.sv
testbench/bpi_flash_model.sv
testbench/tb_bpi_ctrl.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_bpi_ctrl
FILELIST  = bpi_ctrl.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)
LOG       = sim.log
SRCS      = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: $(SIM)
	-./$(SIM) | tee $(LOG)
	grep -q "^all tests passed$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
